// ==== filelist.f ====
mem_pkg.sv
wait_timer.sv
port_access_fsm.sv
mem_array.sv
mem_top.sv
mem_checker.sv
tb_mem_top.sv

// ==== Makefile ====
VERILATOR  = verilator
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
TOP        = tb_mem_top
FILELIST   = filelist.f
PASS_TEXT  = Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf obj_dir

// ==== tb_mem_top.sv ====
`timescale 1ns/100ps

module tb_mem_top;

    localparam int num_random = 300;
    localparam int cycle_limit = 3000; // 300 accesses of at most 6 cycles, boot reads, margin.
    localparam int stall_cycles = 4;

    logic                           clk;
    logic                           reset_n;
    logic                           fetch_read;
    logic [mem_pkg::addr_width-1:0] fetch_addr;
    logic [mem_pkg::word_width-1:0] fetch_data;
    logic                           fetch_stall;
    logic                           data_read;
    logic                           data_write;
    logic [mem_pkg::addr_width-1:0] data_addr;
    logic [mem_pkg::word_width-1:0] data_wdata;
    logic [mem_pkg::word_width-1:0] data_rdata;
    logic                           data_stall;

    logic [mem_pkg::word_width-1:0] model [0:mem_pkg::memory_depth-1];
    logic [mem_pkg::word_width-1:0] last_fetch;
    logic [mem_pkg::word_width-1:0] last_rdata;
    logic [31:0]                    rand_state;
    int                             error_count = 0;
    int                             check_count = 0;
    int                             cycle_count = 0;

    mem_top i_mem_top (
        .clk         (clk),
        .reset_n     (reset_n),
        .fetch_read  (fetch_read),
        .fetch_addr  (fetch_addr),
        .fetch_data  (fetch_data),
        .fetch_stall (fetch_stall),
        .data_read   (data_read),
        .data_write  (data_write),
        .data_addr   (data_addr),
        .data_wdata  (data_wdata),
        .data_rdata  (data_rdata),
        .data_stall  (data_stall)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [31:0] next_random();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state;
    endfunction

    task automatic compare_word(input string what, input logic [15:0] actual,
                                input logic [15:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    // starts in C0, returns in the completion cycle.
    task automatic run_access(input logic f_en, input logic [15:0] f_addr, input logic d_rd,
                              input logic d_wr, input logic [15:0] d_addr, input logic [15:0] d_wdata);
        int stalls;
        stalls = 0;
        fetch_read = f_en;
        fetch_addr = f_addr;
        data_read = d_rd;
        data_write = d_wr;
        data_addr = d_addr;
        data_wdata = d_wdata;
        #1;
        while (fetch_stall || data_stall) begin
            stalls++;
            @(posedge clk);
            #10;
        end
        check_count++;
        if (stalls != stall_cycles) begin
            error_count++;
            $display("CHECK FAILED at %0t: stall lasted %0d cycles, expected %0d",
                     $time, stalls, stall_cycles);
        end
        if (d_rd) begin
            last_rdata = model[d_addr[mem_pkg::index_width-1:0]]; // read beats write.
        end else if (d_wr) begin
            model[d_addr[mem_pkg::index_width-1:0]] = d_wdata;
        end
        if (f_en) begin
            last_fetch = model[f_addr[mem_pkg::index_width-1:0]]; // sees the same-edge write.
        end
        compare_word("data_rdata", data_rdata, last_rdata);
        compare_word("fetch_data", fetch_data, last_fetch);
    endtask

    task automatic drop_requests();
        fetch_read = 1'b0;
        data_read = 1'b0;
        data_write = 1'b0;
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] w;
        logic        f_en;
        logic [1:0]  d_op;
        logic [15:0] f_addr;
        logic [15:0] d_addr;
        rand_state = 32'h2d90;
        reset_n = 1'b0;
        fetch_addr = '0;
        data_addr = '0;
        data_wdata = '0;
        drop_requests();
        last_fetch = '0;
        last_rdata = '0;
        for (int a = 0; a < mem_pkg::memory_depth; a++) begin
            model[a] = (a < mem_pkg::boot_words) ? mem_pkg::boot_image[a] : '0;
        end
        repeat (3) @(posedge clk);
        #10;
        reset_n = 1'b1;
        compare_word("fetch_data after reset", fetch_data, '0);
        compare_word("data_rdata after reset", data_rdata, '0);

        // boot image, then zero words just above it, fetched back to back.
        for (int a = 0; a < 2 * mem_pkg::boot_words; a++) begin
            run_access(1'b1, 16'(a), 1'b0, 1'b0, '0, '0);
            @(posedge clk);
            #10;
        end

        for (int n = 0; n < num_random; n++) begin
            r = next_random();
            w = next_random();
            f_en = r[16] | r[17]; // fetch busy three times in four.
            d_op = r[19:18];
            f_addr = 16'(r[24:20]);
            d_addr = 16'(r[29:25]);
            if (r[31:30] == 2'b00) begin
                d_addr = f_addr; // force a collision.
            end
            if (!f_en && d_op == 2'b00) begin
                f_en = 1'b1;
            end
            run_access(f_en, f_addr, d_op[0], d_op[1], d_addr, w[31:16]);
            if (w[3:0] < 4'd5) begin
                drop_requests();
                @(posedge clk);
                #10;
                check_count++;
                if (fetch_stall || data_stall) begin
                    error_count++;
                    $display("CHECK FAILED at %0t: stall high with no request", $time);
                end
            end
            @(posedge clk);
            #10;
        end
        drop_requests();

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== mem_checker.sv ====
`timescale 1ns/100ps

module mem_checker (
    input logic                             clk,
    input logic                             reset_n,
    input logic                             fetch_read,
    input logic                             data_read,
    input logic                             data_write,
    input logic                             fetch_stall,
    input logic                             data_stall,
    input logic                             fetch_go,
    input logic                             data_go,
    input logic [mem_pkg::timer_width-1:0]  fetch_count,
    input logic [mem_pkg::timer_width-1:0]  data_count,
    input mem_pkg::port_state_e             fetch_state,
    input mem_pkg::port_state_e             data_state
);

    localparam int stall_length = mem_pkg::wait_states + 2; // load, wait states, go.

    fetch_stall_idle: assert property (@(posedge clk) disable iff (!reset_n)
        !fetch_read |-> !fetch_stall) else $error("fetch stall high without a request");

    data_stall_idle: assert property (@(posedge clk) disable iff (!reset_n)
        !(data_read || data_write) |-> !data_stall) else $error("data stall high without a request");

    fetch_stall_length: assert property (@(posedge clk) disable iff (!reset_n)
        $rose(fetch_stall) |-> fetch_stall [*stall_length] ##1 !fetch_stall)
        else $error("fetch stall length wrong");

    data_stall_length: assert property (@(posedge clk) disable iff (!reset_n)
        $rose(data_stall) |-> data_stall [*stall_length] ##1 !data_stall)
        else $error("data stall length wrong");

    fetch_go_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        fetch_go |=> !fetch_go) else $error("fetch go longer than one cycle");

    data_go_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        data_go |=> !data_go) else $error("data go longer than one cycle");

    // both ports idle with empty timers once reset ends.
    reset_state: assert property (@(posedge clk)
        $rose(reset_n) |-> (fetch_state == mem_pkg::port_idle) && (data_state == mem_pkg::port_idle)
                           && (fetch_count == '0) && (data_count == '0))
        else $error("port not idle after reset");

endmodule

bind mem_top mem_checker u_mem_checker (
    .clk         (clk),
    .reset_n     (reset_n),
    .fetch_read  (fetch_read),
    .data_read   (data_read),
    .data_write  (data_write),
    .fetch_stall (fetch_stall),
    .data_stall  (data_stall),
    .fetch_go    (fetch_go),
    .data_go     (data_go),
    .fetch_count (fetch_count),
    .data_count  (data_count),
    .fetch_state (fetch_fsm.state),
    .data_state  (data_fsm.state)
);

// ==== mem_top.sv ====
`timescale 1ns/100ps

module mem_top (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            fetch_read,
    input  logic [mem_pkg::addr_width-1:0]  fetch_addr,
    output logic [mem_pkg::word_width-1:0]  fetch_data,
    output logic                            fetch_stall,
    input  logic                            data_read,
    input  logic                            data_write,
    input  logic [mem_pkg::addr_width-1:0]  data_addr,
    input  logic [mem_pkg::word_width-1:0]  data_wdata,
    output logic [mem_pkg::word_width-1:0]  data_rdata,
    output logic                            data_stall
);

    logic                             data_req;
    logic                             fetch_load;
    logic                             fetch_expired;
    logic                             fetch_go;
    logic [mem_pkg::timer_width-1:0]  fetch_count;
    logic                             data_load;
    logic                             data_expired;
    logic                             data_go;
    logic [mem_pkg::timer_width-1:0]  data_count;

    assign data_req = data_read | data_write; // either kind starts an access.

    port_access_fsm fetch_fsm (
        .clk           (clk),
        .reset_n       (reset_n),
        .req           (fetch_read),
        .timer_expired (fetch_expired),
        .timer_load    (fetch_load),
        .go            (fetch_go),
        .stall         (fetch_stall)
    );

    wait_timer fetch_timer (
        .clk     (clk),
        .reset_n (reset_n),
        .load    (fetch_load),
        .count   (fetch_count),
        .expired (fetch_expired)
    );

    port_access_fsm data_fsm (
        .clk           (clk),
        .reset_n       (reset_n),
        .req           (data_req),
        .timer_expired (data_expired),
        .timer_load    (data_load),
        .go            (data_go),
        .stall         (data_stall)
    );

    wait_timer data_timer (
        .clk     (clk),
        .reset_n (reset_n),
        .load    (data_load),
        .count   (data_count),
        .expired (data_expired)
    );

    mem_array mem_array (
        .clk        (clk),
        .reset_n    (reset_n),
        .fetch_go   (fetch_go),
        .fetch_addr (fetch_addr),
        .fetch_data (fetch_data),
        .data_go    (data_go),
        .data_read  (data_read),
        .data_write (data_write),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_rdata (data_rdata)
    );

endmodule

// ==== mem_array.sv ====
`timescale 1ns/100ps

module mem_array (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            fetch_go,
    input  logic [mem_pkg::addr_width-1:0]  fetch_addr,
    output logic [mem_pkg::word_width-1:0]  fetch_data,
    input  logic                            data_go,
    input  logic                            data_read,
    input  logic                            data_write,
    input  logic [mem_pkg::addr_width-1:0]  data_addr,
    input  logic [mem_pkg::word_width-1:0]  data_wdata,
    output logic [mem_pkg::word_width-1:0]  data_rdata
);

    logic [mem_pkg::word_width-1:0] mem [0:mem_pkg::memory_depth-1];

    logic [mem_pkg::index_width-1:0] fetch_index;
    logic [mem_pkg::index_width-1:0] data_index;
    logic                            data_commit;
    logic                            fetch_hit;

    assign fetch_index = fetch_addr[mem_pkg::index_width-1:0]; // upper bits ignored.
    assign data_index = data_addr[mem_pkg::index_width-1:0];

    // read has priority on the data port.
    assign data_commit = data_go && data_write && !data_read;

    // write landing on the word being fetched at the same edge.
    assign fetch_hit = data_commit && (data_index == fetch_index);

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 0; i < mem_pkg::memory_depth; i++) begin
                if (i < mem_pkg::boot_words) begin
                    mem[i] <= mem_pkg::boot_image[i];
                end else begin
                    mem[i] <= '0;
                end
            end
        end else if (data_commit) begin
            mem[data_index] <= data_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            data_rdata <= '0;
        end else if (data_go && data_read) begin
            data_rdata <= mem[data_index]; // held until the next read.
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            fetch_data <= '0;
        end else if (fetch_go) begin
            if (fetch_hit) begin
                fetch_data <= data_wdata; // forwarded write.
            end else begin
                fetch_data <= mem[fetch_index];
            end
        end
    end

endmodule

// ==== port_access_fsm.sv ====
`timescale 1ns/100ps

module port_access_fsm (
    input  logic clk,
    input  logic reset_n,
    input  logic req,
    input  logic timer_expired,
    output logic timer_load,
    output logic go,
    output logic stall
);

    mem_pkg::port_state_e state;
    mem_pkg::port_state_e state_next;

    always_comb begin
        state_next = state;
        case (state)
            mem_pkg::port_idle: begin
                if (req) begin
                    state_next = mem_pkg::port_wait;
                end
            end
            mem_pkg::port_wait: begin
                if (timer_expired) begin
                    state_next = mem_pkg::port_done;
                end
            end
            mem_pkg::port_done: begin
                state_next = mem_pkg::port_idle; // one cycle with stall low.
            end
            default: begin
                state_next = mem_pkg::port_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state <= mem_pkg::port_idle;
        end else begin
            state <= state_next;
        end
    end

    // start the wait count as the request is accepted.
    assign timer_load = (state == mem_pkg::port_idle) && req;

    // memory acts on the edge that ends this cycle.
    assign go = (state == mem_pkg::port_wait) && timer_expired;

    assign stall = req && (state != mem_pkg::port_done);

endmodule

// ==== wait_timer.sv ====
`timescale 1ns/100ps

module wait_timer (
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic                             load,
    output logic [mem_pkg::timer_width-1:0]  count,
    output logic                             expired
);

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            count <= '0;
        end else if (load) begin
            count <= mem_pkg::timer_width'(mem_pkg::wait_states);
        end else if (count != '0) begin
            count <= count - 1'b1; // stops at zero.
        end
    end

    // a pending load means the count is about to restart.
    assign expired = (count == '0) && !load;

endmodule

// ==== mem_pkg.sv ====
package mem_pkg;

    localparam int word_width = 16;
    localparam int addr_width = 16;
    localparam int memory_depth = 256;
    localparam int index_width = $clog2(memory_depth); // address bits that reach the array.

    localparam int timer_width = 4;
    localparam int wait_states = 2; // timer cycles before the access.

    localparam int boot_words = 8;

    // small start-up program, loaded at address 0 on reset.
    localparam logic [word_width-1:0] boot_image [0:boot_words-1] = '{
        16'h9023,
        16'h0001,
        16'hffff,
        16'h6000,
        16'hf01c,
        16'h6100,
        16'hf41c,
        16'h4401
    };

    typedef enum logic [1:0] {
        port_idle = 2'd0, // waiting for a request.
        port_wait = 2'd1, // wait states running.
        port_done = 2'd2  // access complete, stall low.
    } port_state_e;

endpackage
